//--- verilog/stream_pkg.sv
`default_nettype none

package stream_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // stream line geometry
    ////////////////////////////////////////////////////////////////////////////

    // one line is four flag bits on top of a 32-bit payload word
    localparam int LINE_WIDTH = 36;
    localparam int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] line_data_t;

    // flags sit in bits 35..32, sof is bit 32 and eof bit 33
    typedef struct packed {
        logic [LINE_WIDTH-DATA_WIDTH-3:0] spare;
        logic                             eof;
        logic                             sof;
        line_data_t                       data;
    } stream_line_t;

    ////////////////////////////////////////////////////////////////////////////
    // forward half of a valid/ready stream
    ////////////////////////////////////////////////////////////////////////////

    // ready runs the other way as a plain one-bit port
    typedef struct packed {
        stream_line_t line;
        logic         valid;
    } stream_src_t;

endpackage

`default_nettype wire

//--- verilog/inspect_pkg.sv
`default_nettype none

package inspect_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // header buffer geometry
    ////////////////////////////////////////////////////////////////////////////

    // padded ethernet + ip + udp + vrt header
    localparam int NUM_HDR_LINES = 12;

    typedef logic [3:0] hdr_index_t;

    // first line handed to the dsp, this is the vrt header
    localparam hdr_index_t DSP_LINE_OFFSET = 4'd11;

    ////////////////////////////////////////////////////////////////////////////
    // match constants for udp data packets
    ////////////////////////////////////////////////////////////////////////////

    // ethertype in low 16 bits
    localparam int          ETHERTYPE_LINE = 3;
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

    // ip protocol in bits 23..16
    localparam int          PROTO_LINE = 6;
    localparam logic [7:0]  PROTO_UDP  = 8'h11;

    // udp destination port in low 16 bits
    localparam int          UDP_PORT_LINE = 9;
    localparam logic [15:0] UDP_DATA_PORT = 16'd49153;

    ////////////////////////////////////////////////////////////////////////////
    // inspector FSM and destination
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        READ_PRE,
        READ_HDR,
        WRITE_REGS,
        WRITE_LIVE
    } insp_state_e;

    typedef enum logic {
        DEST_DSP,
        DEST_CPU
    } insp_dest_e;

endpackage

`default_nettype wire

//--- verilog/frame_combiner.sv
`timescale 1ns/1ps
`default_nettype none

module frame_combiner (
    input  logic                   stream_clk,
    input  logic                   stream_rst,
    input  stream_pkg::stream_src_t eth_i,
    output logic                   eth_ready_o,
    input  stream_pkg::stream_src_t ser_i,
    output logic                   ser_ready_o,
    output stream_pkg::stream_src_t com_o,
    input  logic                   com_ready_i
);
    import stream_pkg::*;

    typedef enum logic [1:0] {
        GRANT_IDLE,
        GRANT_ETH,
        GRANT_SER
    } grant_e;

    grant_e grant;
    logic   eth_xfer;
    logic   ser_xfer;

    ////////////////////////////////////////////////////////////////////////////
    // data path, purely combinational from granted source
    ////////////////////////////////////////////////////////////////////////////

    // only the granted source sees ready, nobody while idle
    assign eth_ready_o = (grant == GRANT_ETH) & com_ready_i;
    assign ser_ready_o = (grant == GRANT_SER) & com_ready_i;

    assign eth_xfer = eth_i.valid & eth_ready_o;
    assign ser_xfer = ser_i.valid & ser_ready_o;

    always_comb begin
        com_o       = eth_i;
        com_o.valid = 1'b0;
        case (grant)
            GRANT_ETH: com_o = eth_i;
            GRANT_SER: com_o = ser_i;
            default:   com_o.valid = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // grant register, held for a whole packet
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge stream_clk) begin
        if (stream_rst) begin
            grant <= GRANT_IDLE;
        end else begin
            case (grant)
                GRANT_IDLE: begin
                    // ethernet has priority when both are waiting
                    if (eth_i.valid) begin
                        grant <= GRANT_ETH;
                    end else if (ser_i.valid) begin
                        grant <= GRANT_SER;
                    end
                end
                GRANT_ETH: begin
                    if (eth_xfer & eth_i.line.eof) begin
                        grant <= GRANT_IDLE;
                    end
                end
                GRANT_SER: begin
                    if (ser_xfer & ser_i.line.eof) begin
                        grant <= GRANT_IDLE;
                    end
                end
                default: grant <= GRANT_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/com_inspector.sv
`timescale 1ns/1ps
`default_nettype none

module com_inspector (
    input  logic                    stream_clk,
    input  logic                    stream_rst,
    input  stream_pkg::stream_src_t com_i,
    output logic                    com_ready_o,
    output stream_pkg::stream_src_t cpu_o,
    input  logic                    cpu_ready_i,
    output stream_pkg::stream_src_t dsp_o,
    input  logic                    dsp_ready_i
);
    import stream_pkg::*;
    import inspect_pkg::*;

    insp_state_e  state;
    insp_dest_e   dest;
    hdr_index_t   hdr_count;
    hdr_index_t   hdr_count_next;
    logic         hdr_last;
    logic         hdr_we;
    logic         hdr_match;
    logic         first_dsp_line;

    // buffered header lines
    stream_line_t hdr_q [NUM_HDR_LINES];

    stream_line_t out_line;
    logic         out_valid;
    logic         out_ready;
    logic         in_xfer;
    logic         out_xfer;

    assign hdr_count_next = hdr_count + 4'd1;
    assign hdr_last       = (hdr_count == hdr_index_t'(NUM_HDR_LINES - 1));

    ////////////////////////////////////////////////////////////////////////////
    // classification
    ////////////////////////////////////////////////////////////////////////////

    // evaluated as the twelfth line arrives while the vrt header is still on the input
    assign hdr_match = (hdr_q[ETHERTYPE_LINE].data[15:0] == ETHERTYPE_IPV4)
                     & (hdr_q[PROTO_LINE].data[23:16] == PROTO_UDP)
                     & (hdr_q[UDP_PORT_LINE].data[15:0] == UDP_DATA_PORT)
                     & (com_i.line.data != '0);

    ////////////////////////////////////////////////////////////////////////////
    // output steering
    ////////////////////////////////////////////////////////////////////////////

    assign first_dsp_line = (dest == DEST_DSP) & (hdr_count == DSP_LINE_OFFSET);

    always_comb begin
        out_line = com_i.line;
        if (state == WRITE_REGS) begin
            out_line = hdr_q[hdr_count];
            // dsp frame starts mid packet and gets a fresh sof
            if (first_dsp_line) begin
                out_line.spare = '0;
                out_line.eof   = 1'b0;
                out_line.sof   = 1'b1;
            end
        end
    end

    assign out_valid = (state == WRITE_REGS) | ((state == WRITE_LIVE) & com_i.valid);
    assign out_ready = (dest == DEST_DSP) ? dsp_ready_i : cpu_ready_i;
    assign out_xfer  = out_valid & out_ready;

    always_comb begin
        cpu_o.line  = out_line;
        cpu_o.valid = (dest == DEST_CPU) & out_valid;
        dsp_o.line  = out_line;
        dsp_o.valid = (dest == DEST_DSP) & out_valid;
    end

    // always accepting while buffering and following the sink when live
    always_comb begin
        case (state)
            READ_PRE:   com_ready_o = 1'b1;
            READ_HDR:   com_ready_o = 1'b1;
            WRITE_LIVE: com_ready_o = out_ready;
            default:    com_ready_o = 1'b0;
        endcase
    end

    assign in_xfer = com_i.valid & com_ready_o;

    ////////////////////////////////////////////////////////////////////////////
    // header buffer
    ////////////////////////////////////////////////////////////////////////////

    assign hdr_we = in_xfer & (((state == READ_PRE) & com_i.line.sof) | (state == READ_HDR));

    always_ff @(posedge stream_clk) begin
        if (hdr_we) begin
            hdr_q[hdr_count] <= com_i.line;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // inspector FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge stream_clk) begin
        if (stream_rst) begin
            state     <= READ_PRE;
            dest      <= DEST_CPU;
            hdr_count <= '0;
        end else begin
            case (state)
                READ_PRE: begin
                    // lines outside a packet are dropped here
                    if (in_xfer & com_i.line.sof) begin
                        if (com_i.line.eof) begin
                            dest      <= DEST_CPU;
                            state     <= WRITE_REGS;
                            hdr_count <= '0;
                        end else begin
                            state     <= READ_HDR;
                            hdr_count <= hdr_count_next;
                        end
                    end
                end
                READ_HDR: begin
                    if (in_xfer) begin
                        if (hdr_last & hdr_match) begin
                            dest      <= DEST_DSP;
                            state     <= WRITE_REGS;
                            hdr_count <= DSP_LINE_OFFSET;
                        end else if (hdr_last | com_i.line.eof) begin
                            dest      <= DEST_CPU;
                            state     <= WRITE_REGS;
                            hdr_count <= '0;
                        end else begin
                            hdr_count <= hdr_count_next;
                        end
                    end
                end
                WRITE_REGS: begin
                    if (out_xfer) begin
                        if (out_line.eof) begin
                            state     <= READ_PRE;
                            hdr_count <= '0;
                        end else if (hdr_last) begin
                            state     <= WRITE_LIVE;
                            hdr_count <= '0;
                        end else begin
                            hdr_count <= hdr_count_next;
                        end
                    end
                end
                WRITE_LIVE: begin
                    if (out_xfer & out_line.eof) begin
                        state <= READ_PRE;
                    end
                end
                default: state <= READ_PRE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/packet_router.sv
`timescale 1ns/1ps
`default_nettype none

module packet_router (
    input  logic                    stream_clk,
    input  logic                    stream_rst,

    // ethernet and serdes inputs
    input  stream_pkg::stream_src_t eth_inp_i,
    output logic                    eth_inp_ready_o,
    input  stream_pkg::stream_src_t ser_inp_i,
    output logic                    ser_inp_ready_o,

    // cpu and dsp outputs
    output stream_pkg::stream_src_t cpu_out_o,
    input  logic                    cpu_out_ready_i,
    output stream_pkg::stream_src_t dsp_out_o,
    input  logic                    dsp_out_ready_i
);
    import stream_pkg::*;

    // merged communication stream
    stream_src_t com;
    logic        com_ready;

    ////////////////////////////////////////////////////////////////////////////
    // input combiner, one whole packet at a time
    ////////////////////////////////////////////////////////////////////////////

    frame_combiner i_frame_combiner (
        .stream_clk  (stream_clk),
        .stream_rst  (stream_rst),
        .eth_i       (eth_inp_i),
        .eth_ready_o (eth_inp_ready_o),
        .ser_i       (ser_inp_i),
        .ser_ready_o (ser_inp_ready_o),
        .com_o       (com),
        .com_ready_i (com_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // inspector, sends udp data to the dsp and the rest to the cpu
    ////////////////////////////////////////////////////////////////////////////

    com_inspector i_com_inspector (
        .stream_clk  (stream_clk),
        .stream_rst  (stream_rst),
        .com_i       (com),
        .com_ready_o (com_ready),
        .cpu_o       (cpu_out_o),
        .cpu_ready_i (cpu_out_ready_i),
        .dsp_o       (dsp_out_o),
        .dsp_ready_i (dsp_out_ready_i)
    );

endmodule

`default_nettype wire

//--- test/packet_router_properties.sv
`timescale 1ns/1ps
`default_nettype none

module packet_router_properties (
    input  logic                    stream_clk,
    input  logic                    stream_rst,
    input  stream_pkg::stream_src_t com_i,
    input  logic                    com_ready_i,
    input  stream_pkg::stream_src_t cpu_i,
    input  logic                    cpu_ready_i,
    input  stream_pkg::stream_src_t dsp_i,
    input  logic                    dsp_ready_i
);

    ////////////////////////////////////////////////////////////////////////////
    // valid/ready rule, a stalled line stays put until it transfers
    ////////////////////////////////////////////////////////////////////////////

    com_hold_a: assert property (
        @(posedge stream_clk) disable iff (stream_rst)
        (com_i.valid && !com_ready_i) |=> (com_i.valid && $stable(com_i.line))
    ) else $error("com line dropped or changed while stalled");

    cpu_hold_a: assert property (
        @(posedge stream_clk) disable iff (stream_rst)
        (cpu_i.valid && !cpu_ready_i) |=> (cpu_i.valid && $stable(cpu_i.line))
    ) else $error("cpu line dropped or changed while stalled");

    dsp_hold_a: assert property (
        @(posedge stream_clk) disable iff (stream_rst)
        (dsp_i.valid && !dsp_ready_i) |=> (dsp_i.valid && $stable(dsp_i.line))
    ) else $error("dsp line dropped or changed while stalled");

    ////////////////////////////////////////////////////////////////////////////
    // steering
    ////////////////////////////////////////////////////////////////////////////

    // one packet in flight, so only one sink can be active
    one_sink_a: assert property (
        @(posedge stream_clk) disable iff (stream_rst)
        !(cpu_i.valid && dsp_i.valid)
    ) else $error("cpu and dsp outputs valid together");

    reset_quiet_a: assert property (
        @(posedge stream_clk) stream_rst |=> (!cpu_i.valid && !dsp_i.valid)
    ) else $error("output valid right after reset");

endmodule

`default_nettype wire

//--- test/tb_packet_router.sv
`timescale 1ns/1ps
`default_nettype none

module tb_packet_router;
    import stream_pkg::*;

    localparam int GROUP_TIMEOUT = 500;
    localparam int QUIET_CYCLES  = 20;
    localparam int NEWLINE       = 10;

    logic        stream_clk = 1'b0;
    logic        stream_rst;
    stream_src_t eth_inp;
    logic        eth_inp_ready;
    stream_src_t ser_inp;
    logic        ser_inp_ready;
    stream_src_t cpu_out;
    logic        cpu_out_ready;
    stream_src_t dsp_out;
    logic        dsp_out_ready;

    integer seed;

    // pending input lines and expected output lines of the current group
    stream_line_t eth_q[$];
    stream_line_t ser_q[$];
    stream_line_t exp_cpu_q[$];
    stream_line_t exp_dsp_q[$];

    packet_router i_packet_router (
        .stream_clk      (stream_clk),
        .stream_rst      (stream_rst),
        .eth_inp_i       (eth_inp),
        .eth_inp_ready_o (eth_inp_ready),
        .ser_inp_i       (ser_inp),
        .ser_inp_ready_o (ser_inp_ready),
        .cpu_out_o       (cpu_out),
        .cpu_out_ready_i (cpu_out_ready),
        .dsp_out_o       (dsp_out),
        .dsp_out_ready_i (dsp_out_ready)
    );

    bind com_inspector packet_router_properties i_packet_router_properties (
        .stream_clk  (stream_clk),
        .stream_rst  (stream_rst),
        .com_i       (com_i),
        .com_ready_i (com_ready_o),
        .cpu_i       (cpu_o),
        .cpu_ready_i (cpu_ready_i),
        .dsp_i       (dsp_o),
        .dsp_ready_i (dsp_ready_i)
    );

    always #50 stream_clk = ~stream_clk;

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_line(input string grp, input string sink,
                              input stream_line_t exp, input stream_line_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s: %s line expected %09h actual %09h",
                                grp, sink, exp, act));
        end
    endtask

    task automatic check_count(input string grp, input string what,
                               input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("FAILED %s: %s expected %0d actual %0d",
                                grp, what, exp, act));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    // flags nibble holds spare, eof and sof from the top
    function automatic stream_line_t make_line(input logic [3:0] flags, input line_data_t data);
        stream_line_t l;
        l.spare = flags[3:2];
        l.eof   = flags[1];
        l.sof   = flags[0];
        l.data  = data;
        return l;
    endfunction

    // sources present their queue head and sinks are ready about 3 cycles in 4
    task automatic drive_inputs();
        eth_inp.valid = (eth_q.size() != 0);
        if (eth_inp.valid) begin
            eth_inp.line = eth_q[0];
        end
        ser_inp.valid = (ser_q.size() != 0);
        if (ser_inp.valid) begin
            ser_inp.line = ser_q[0];
        end
        cpu_out_ready = (($random(seed) & 3) != 0);
        dsp_out_ready = (($random(seed) & 3) != 0);
    endtask

    task automatic run_group(input string grp);
        int           cycles;
        int           eof_total;
        int           eof_seen;
        stream_line_t exp;
        cycles    = 0;
        eof_total = 0;
        eof_seen  = 0;
        // every input packet leaves on exactly one sink and ends with an eof line
        foreach (eth_q[i]) begin
            if (eth_q[i].eof) begin
                eof_total++;
            end
        end
        foreach (ser_q[i]) begin
            if (ser_q[i].eof) begin
                eof_total++;
            end
        end
        while (((eth_q.size() + ser_q.size()) != 0) || (eof_seen < eof_total)) begin
            if (cycles == GROUP_TIMEOUT) begin
                abort_run($sformatf("timeout in group %s with lines still outstanding", grp));
            end
            drive_inputs();
            // everything is settled mid cycle and the transfer happens on the next rising edge
            @(negedge stream_clk);
            if (eth_inp.valid && eth_inp_ready) begin
                void'(eth_q.pop_front());
            end
            if (ser_inp.valid && ser_inp_ready) begin
                void'(ser_q.pop_front());
            end
            if (cpu_out.valid && cpu_out_ready) begin
                if (exp_cpu_q.size() == 0) begin
                    abort_run($sformatf("group %s sent an unexpected line to the cpu", grp));
                end else begin
                    exp = exp_cpu_q.pop_front();
                    check_line(grp, "cpu", exp, cpu_out.line);
                    if (cpu_out.line.eof) begin
                        eof_seen++;
                    end
                end
            end
            if (dsp_out.valid && dsp_out_ready) begin
                if (exp_dsp_q.size() == 0) begin
                    abort_run($sformatf("group %s sent an unexpected line to the dsp", grp));
                end else begin
                    exp = exp_dsp_q.pop_front();
                    check_line(grp, "dsp", exp, dsp_out.line);
                    if (dsp_out.line.eof) begin
                        eof_seen++;
                    end
                end
            end
            @(posedge stream_clk);
            #1;
            cycles++;
        end
        eth_inp.valid = 1'b0;
        ser_inp.valid = 1'b0;
        check_count(grp, "cpu lines still expected", 0, exp_cpu_q.size());
        check_count(grp, "dsp lines still expected", 0, exp_dsp_q.size());
        $display("group %s done after %0d cycles", grp, cycles);
    endtask

    task automatic run_file();
        int           fd;
        int           code;
        int           ch;
        int           groups;
        logic         done;
        string        kind;
        string        port;
        string        grp;
        logic [3:0]   flags;
        line_data_t   data;
        stream_line_t l;
        groups = 0;
        done   = 1'b0;
        fd = $fopen("test/packet_router_input.txt", "r");
        if (fd == 0) begin
            abort_run("could not open test/packet_router_input.txt");
        end
        while (!done) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                ch = $fgetc(fd);
                while (ch != NEWLINE && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (kind == "G") begin
                code = $fscanf(fd, "%s", grp);
                run_group(grp);
                groups++;
            end else if (kind == "I" || kind == "E") begin
                code = $fscanf(fd, "%s %h %h", port, flags, data);
                if (code != 3) begin
                    abort_run($sformatf("malformed %s record in the input file", kind));
                end
                l = make_line(flags, data);
                if (kind == "I" && port == "eth") begin
                    eth_q.push_back(l);
                end else if (kind == "I" && port == "ser") begin
                    ser_q.push_back(l);
                end else if (kind == "E" && port == "cpu") begin
                    exp_cpu_q.push_back(l);
                end else if (kind == "E" && port == "dsp") begin
                    exp_dsp_q.push_back(l);
                end else begin
                    abort_run($sformatf("record %s names unknown port %s", kind, port));
                end
            end else begin
                abort_run($sformatf("unknown record kind %s in the input file", kind));
            end
        end
        $fclose(fd);
        check_count("input file", "groups above zero", 1, int'(groups > 0));
        check_count("input file", "records after last group", 0,
                    eth_q.size() + ser_q.size() + exp_cpu_q.size() + exp_dsp_q.size());
    endtask

    // nothing may come out once every packet has been delivered
    task automatic check_quiet();
        int i;
        cpu_out_ready = 1'b1;
        dsp_out_ready = 1'b1;
        for (i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge stream_clk);
            if (cpu_out.valid || dsp_out.valid) begin
                abort_run("an output went valid after the last packet was delivered");
            end
            @(posedge stream_clk);
        end
    endtask

    initial begin
        stream_rst    = 1'b1;
        eth_inp       = '0;
        ser_inp       = '0;
        cpu_out_ready = 1'b0;
        dsp_out_ready = 1'b0;
        seed          = 32'h0691_5385;
        repeat (3) @(posedge stream_clk);
        #1;
        stream_rst = 1'b0;
        run_file();
        check_quiet();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- packet_router.f
verilog/stream_pkg.sv
verilog/inspect_pkg.sv
verilog/frame_combiner.sv
verilog/com_inspector.sv
verilog/packet_router.sv
test/packet_router_properties.sv
test/tb_packet_router.sv

//--- run_sim.sh
#!/bin/sh
# builds the packet router testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_packet_router -f packet_router.f

# show the model output and look for the pass line in it
./obj_dir/Vtb_packet_router | tee /dev/stderr | grep "^TEST OK$" > /dev/null

echo "simulation passed"

//--- test/packet_router_input.txt
# I <eth|ser> <flags> <data> is an input line, E <cpu|dsp> <flags> <data> an expected line
# G <name> runs the group, flags hex with bit 0 sof and bit 1 eof, data 32-bit hex
I eth 1 0a000000
I eth 0 0a000001
I eth 0 0a000002
I eth 0 00000800
I eth 0 0a000004
I eth 0 0a000005
I eth 0 40110000
I eth 0 0a000007
I eth 0 0a000008
I eth 0 8000c001
I eth 0 0a00000a
I eth 0 1c000123
I eth 0 d0000012
I eth 0 d0000013
I eth 0 d0000014
I eth 2 d0000015
E dsp 1 1c000123
E dsp 0 d0000012
E dsp 0 d0000013
E dsp 0 d0000014
E dsp 2 d0000015
G udp_match
I ser 1 0b000000
I ser 0 0b000001
I ser 0 0b000002
I ser 0 00000800
I ser 0 0b000004
I ser 0 0b000005
I ser 0 40110000
I ser 0 0b000007
I ser 0 0b000008
I ser 0 8000c002
I ser 0 0b00000a
I ser 0 1c000124
I ser 0 0b00000c
I ser 0 0b00000d
I ser 0 0b00000e
I ser 2 0b00000f
E cpu 1 0b000000
E cpu 0 0b000001
E cpu 0 0b000002
E cpu 0 00000800
E cpu 0 0b000004
E cpu 0 0b000005
E cpu 0 40110000
E cpu 0 0b000007
E cpu 0 0b000008
E cpu 0 8000c002
E cpu 0 0b00000a
E cpu 0 1c000124
E cpu 0 0b00000c
E cpu 0 0b00000d
E cpu 0 0b00000e
E cpu 2 0b00000f
G wrong_port
I eth 1 0c000000
I eth 0 0c000001
I eth 2 0c000002
I eth 3 0c0000ff
E cpu 1 0c000000
E cpu 0 0c000001
E cpu 2 0c000002
E cpu 3 0c0000ff
G short_packet
I eth 1 0d000000
I eth 0 0d000001
I eth 0 0d000002
I eth 0 00000800
I eth 0 0d000004
I eth 0 0d000005
I eth 0 40110000
I eth 0 0d000007
I eth 0 0d000008
I eth 0 8000c001
I eth 0 0d00000a
I eth 2 00000000
E cpu 1 0d000000
E cpu 0 0d000001
E cpu 0 0d000002
E cpu 0 00000800
E cpu 0 0d000004
E cpu 0 0d000005
E cpu 0 40110000
E cpu 0 0d000007
E cpu 0 0d000008
E cpu 0 8000c001
E cpu 0 0d00000a
E cpu 2 00000000
G zero_vrt
I eth 1 0e000000
I eth 0 0e000001
I eth 2 0e000002
I ser 1 0f000000
I ser 2 0f000001
E cpu 1 0e000000
E cpu 0 0e000001
E cpu 2 0e000002
E cpu 1 0f000000
E cpu 2 0f000001
G dual_source
